// ==== rtl/soc_map_pkg.sv ====
//////////////////////////////////////////////////
// SoC memory map
// Region codes on address bits 31:24, GPIO
// register word indices, and the two views of
// a bus address word
//////////////////////////////////////////////////

package soc_map_pkg;

    //////////////////////////////////////////////////
    // Regions
    //////////////////////////////////////////////////

    // SRAM at 0x00xx_xxxx
    localparam logic [7:0] REGION_SRAM = 8'h00;
    // GPIO at 0x03xx_xxxx
    localparam logic [7:0] REGION_GPIO = 8'h03;

    //////////////////////////////////////////////////
    // GPIO registers
    //////////////////////////////////////////////////

    localparam logic [21:0] GPIO_LED_WORD = 22'd0;
    localparam logic [21:0] GPIO_BTN_WORD = 22'd1;

    //////////////////////////////////////////////////
    // Address views
    //////////////////////////////////////////////////

    // Region select plus byte offset inside the region
    typedef struct packed {
        logic [7:0]  region;
        logic [23:0] offset;
    } addr_map_t;

    // Region select plus word index and byte lane
    typedef struct packed {
        logic [7:0]  region;
        logic [21:0] word;
        logic [1:0]  byte_sel;
    } addr_word_t;

    typedef union packed {
        addr_map_t  map;
        addr_word_t word;
    } iomem_addr_u;

endpackage

// ==== rtl/soc_bus_pkg.sv ====
//////////////////////////////////////////////////
// Peripheral bus transaction types
// Request and response words shared by masters,
// arbiter, decoder and peripherals
//////////////////////////////////////////////////

package soc_bus_pkg;

    //////////////////////////////////////////////////
    // Request
    //////////////////////////////////////////////////

    // Held stable from valid until ready
    // A nonzero wstrb marks a write
    typedef struct packed {
        logic                     valid;
        logic [3:0]               wstrb;
        soc_map_pkg::iomem_addr_u addr;
        logic [31:0]              wdata;
    } iomem_req_t;

    //////////////////////////////////////////////////
    // Response
    //////////////////////////////////////////////////

    // ready is a one-cycle pulse that ends the transfer
    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } iomem_rsp_t;

    //////////////////////////////////////////////////
    // Masters
    //////////////////////////////////////////////////

    // Processor side and host bridge side
    typedef enum logic {
        MASTER_CPU  = 1'b0,
        MASTER_HOST = 1'b1
    } master_sel_e;

endpackage

// ==== rtl/iomem_arbiter.sv ====
//////////////////////////////////////////////////
// Peripheral bus arbiter
// Round-robin grant between the cpu and host
// masters, one transfer per grant
//////////////////////////////////////////////////

module iomem_arbiter (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  soc_bus_pkg::iomem_req_t cpu_req_i,
    output soc_bus_pkg::iomem_rsp_t cpu_rsp_o,
    input  soc_bus_pkg::iomem_req_t host_req_i,
    output soc_bus_pkg::iomem_rsp_t host_rsp_o,
    output soc_bus_pkg::iomem_req_t bus_req_o,
    input  soc_bus_pkg::iomem_rsp_t bus_rsp_i
);

    logic                     grant_q;
    soc_bus_pkg::master_sel_e owner_q;
    soc_bus_pkg::master_sel_e last_q;
    soc_bus_pkg::master_sel_e next_owner;

    // On a tie the master not served last wins
    always_comb begin
        if (cpu_req_i.valid && host_req_i.valid) begin
            next_owner = (last_q == soc_bus_pkg::MASTER_CPU) ? soc_bus_pkg::MASTER_HOST
                                                             : soc_bus_pkg::MASTER_CPU;
        end else if (cpu_req_i.valid) begin
            next_owner = soc_bus_pkg::MASTER_CPU;
        end else begin
            next_owner = soc_bus_pkg::MASTER_HOST;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            grant_q <= 1'b0;
            owner_q <= soc_bus_pkg::MASTER_CPU;
            last_q  <= soc_bus_pkg::MASTER_HOST;
        end else if (!grant_q) begin
            if (cpu_req_i.valid || host_req_i.valid) begin
                grant_q <= 1'b1;
                owner_q <= next_owner;
            end
        end else if (bus_rsp_i.ready) begin
            // Release here so the bus sees one idle cycle
            grant_q <= 1'b0;
            last_q  <= owner_q;
        end
    end

    always_comb begin
        bus_req_o = (owner_q == soc_bus_pkg::MASTER_CPU) ? cpu_req_i : host_req_i;
        bus_req_o.valid = grant_q && bus_req_o.valid;
    end

    // Response only reaches the owner
    always_comb begin
        cpu_rsp_o.rdata  = bus_rsp_i.rdata;
        cpu_rsp_o.ready  = bus_rsp_i.ready && grant_q
                           && (owner_q == soc_bus_pkg::MASTER_CPU);
        host_rsp_o.rdata = bus_rsp_i.rdata;
        host_rsp_o.ready = bus_rsp_i.ready && grant_q
                           && (owner_q == soc_bus_pkg::MASTER_HOST);
    end

    cpu_ready_not_while_host_owns: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(cpu_rsp_o.ready) |-> !(grant_q && owner_q == soc_bus_pkg::MASTER_HOST)
    ) else $error("cpu ready raised while host holds the grant");

    host_ready_not_while_cpu_owns: assert property (
        @(posedge clk_i) disable iff (rst_i)
        $rose(host_rsp_o.ready) |-> !(grant_q && owner_q == soc_bus_pkg::MASTER_CPU)
    ) else $error("host ready raised while cpu holds the grant");

endmodule

// ==== rtl/iomem_decoder.sv ====
//////////////////////////////////////////////////
// Peripheral bus decoder
// Routes the bus request by region and selects
// the matching response; unmapped regions answer
// at once with zero data
//////////////////////////////////////////////////

module iomem_decoder (
    input  logic                    clk_i,
    input  soc_bus_pkg::iomem_req_t bus_req_i,
    output soc_bus_pkg::iomem_rsp_t bus_rsp_o,
    output soc_bus_pkg::iomem_req_t sram_req_o,
    input  soc_bus_pkg::iomem_rsp_t sram_rsp_i,
    output soc_bus_pkg::iomem_req_t gpio_req_o,
    input  soc_bus_pkg::iomem_rsp_t gpio_rsp_i
);

    logic sram_hit;
    logic gpio_hit;

    assign sram_hit = (bus_req_i.addr.map.region == soc_map_pkg::REGION_SRAM);
    assign gpio_hit = (bus_req_i.addr.map.region == soc_map_pkg::REGION_GPIO);

    //////////////////////////////////////////////////
    // Request routing
    //////////////////////////////////////////////////

    // Payload goes to both, valid only to the hit
    always_comb begin
        sram_req_o       = bus_req_i;
        sram_req_o.valid = bus_req_i.valid && sram_hit;
        gpio_req_o       = bus_req_i;
        gpio_req_o.valid = bus_req_i.valid && gpio_hit;
    end

    //////////////////////////////////////////////////
    // Response select
    //////////////////////////////////////////////////

    always_comb begin
        if (sram_hit) begin
            bus_rsp_o = sram_rsp_i;
        end else if (gpio_hit) begin
            bus_rsp_o = gpio_rsp_i;
        end else begin
            // Nothing mapped here
            bus_rsp_o.ready = bus_req_i.valid;
            bus_rsp_o.rdata = 32'h0;
        end
    end

    one_peripheral_selected: assert property (
        @(posedge clk_i)
        sram_req_o.valid |-> !gpio_req_o.valid
    ) else $error("SRAM and GPIO selected in the same cycle");

endmodule

// ==== rtl/soc_sram.sv ====
//////////////////////////////////////////////////
// Block-RAM SRAM peripheral
// Word-wide memory with byte write strobes,
// registered read data and one-cycle ready
//////////////////////////////////////////////////

module soc_sram #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  soc_bus_pkg::iomem_req_t req_i,
    output soc_bus_pkg::iomem_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    logic [31:0]      mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ready_q;
    logic [31:0]      rdata_q;

    // Word index wraps at the memory size
    assign idx    = req_i.addr.word.word[IDX_W-1:0];
    assign access = req_i.valid && !ready_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= access;
        end
    end

    // Array and read register
    always_ff @(posedge clk_i) begin
        if (access) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req_i.wstrb[lane]) begin
                    mem[idx][lane*8 +: 8] <= req_i.wdata[lane*8 +: 8];
                end
            end
            rdata_q <= mem[idx];
        end
    end

    assign rsp_o.ready = ready_q;
    assign rsp_o.rdata = rdata_q;

    ready_single_pulse: assert property (
        @(posedge clk_i) disable iff (rst_i)
        rsp_o.ready |=> !rsp_o.ready
    ) else $error("SRAM ready held for two cycles");

endmodule

// ==== rtl/soc_gpio.sv ====
//////////////////////////////////////////////////
// GPIO peripheral
// One LED register and one synchronized button,
// both read back over the bus
//////////////////////////////////////////////////

module soc_gpio (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  soc_bus_pkg::iomem_req_t req_i,
    output soc_bus_pkg::iomem_rsp_t rsp_o,
    input  logic                    button_i,
    output logic                    led_o
);

    logic        access;
    logic [21:0] word;
    logic        btn_meta;
    logic        btn_sync;
    logic        led_q;
    logic        ready_q;
    logic [31:0] rdata_q;

    assign word   = req_i.addr.word.word;
    assign access = req_i.valid && !ready_q;

    //////////////////////////////////////////////////
    // Control and pins
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            btn_meta <= 1'b0;
            btn_sync <= 1'b0;
            led_q    <= 1'b0;
            ready_q  <= 1'b0;
        end else begin
            // Two-flop synchronizer for the async button
            btn_meta <= button_i;
            btn_sync <= btn_meta;
            ready_q  <= access;
            if (access && word == soc_map_pkg::GPIO_LED_WORD && req_i.wstrb[0]) begin
                led_q <= req_i.wdata[0];
            end
        end
    end

    // Read mux, unknown words give zero
    always_ff @(posedge clk_i) begin
        if (access) begin
            case (word)
                soc_map_pkg::GPIO_LED_WORD: rdata_q <= {31'h0, led_q};
                soc_map_pkg::GPIO_BTN_WORD: rdata_q <= {31'h0, btn_sync};
                default:                    rdata_q <= 32'h0;
            endcase
        end
    end

    assign rsp_o.ready = ready_q;
    assign rsp_o.rdata = rdata_q;
    assign led_o       = led_q;

endmodule

// ==== rtl/soc_bus_top.sv ====
//////////////////////////////////////////////////
// Peripheral bus top level
// Two masters share one bus through the arbiter;
// the decoder fans out to SRAM and GPIO
//////////////////////////////////////////////////

module soc_bus_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  soc_bus_pkg::iomem_req_t cpu_req_i,
    output soc_bus_pkg::iomem_rsp_t cpu_rsp_o,
    input  soc_bus_pkg::iomem_req_t host_req_i,
    output soc_bus_pkg::iomem_rsp_t host_rsp_o,
    input  logic                    button_i,
    output logic                    led_o
);

    soc_bus_pkg::iomem_req_t bus_req;
    soc_bus_pkg::iomem_rsp_t bus_rsp;
    soc_bus_pkg::iomem_req_t sram_req;
    soc_bus_pkg::iomem_rsp_t sram_rsp;
    soc_bus_pkg::iomem_req_t gpio_req;
    soc_bus_pkg::iomem_rsp_t gpio_rsp;

    iomem_arbiter arbiter_inst (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .cpu_req_i  (cpu_req_i),
        .cpu_rsp_o  (cpu_rsp_o),
        .host_req_i (host_req_i),
        .host_rsp_o (host_rsp_o),
        .bus_req_o  (bus_req),
        .bus_rsp_i  (bus_rsp)
    );

    iomem_decoder decoder_inst (
        .clk_i      (clk_i),
        .bus_req_i  (bus_req),
        .bus_rsp_o  (bus_rsp),
        .sram_req_o (sram_req),
        .sram_rsp_i (sram_rsp),
        .gpio_req_o (gpio_req),
        .gpio_rsp_i (gpio_rsp)
    );

    soc_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) sram_inst (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (sram_req),
        .rsp_o (sram_rsp)
    );

    soc_gpio gpio_inst (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .req_i    (gpio_req),
        .rsp_o    (gpio_rsp),
        .button_i (button_i),
        .led_o    (led_o)
    );

endmodule

// ==== tests/soc_bus_tb.sv ====
//////////////////////////////////////////////////
// Peripheral bus testbench
// Plays the cpu and host masters against the bus
// top level and checks SRAM, GPIO and arbitration
//////////////////////////////////////////////////

module soc_bus_tb;

    localparam int NUM_TXNS   = 37;
    localparam int MODEL_WORDS = 12;

    logic                    clk;
    logic                    rst;
    soc_bus_pkg::iomem_req_t cpu_req;
    soc_bus_pkg::iomem_rsp_t cpu_rsp;
    soc_bus_pkg::iomem_req_t host_req;
    soc_bus_pkg::iomem_rsp_t host_rsp;
    logic                    button;
    logic                    led;

    int         errors = 0;
    logic [7:0] sram_model [MODEL_WORDS*4];
    bit         done_order [$];

    soc_bus_top #(
        .MEM_WORDS (256)
    ) soc_bus_top_inst (
        .clk_i      (clk),
        .rst_i      (rst),
        .cpu_req_i  (cpu_req),
        .cpu_rsp_o  (cpu_rsp),
        .host_req_i (host_req),
        .host_rsp_o (host_rsp),
        .button_i   (button),
        .led_o      (led)
    );

    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Protocol checks
    //////////////////////////////////////////////////

    reset_outputs_low: assert property (
        @(posedge clk) rst |=> !cpu_rsp.ready && !host_rsp.ready && !led
    ) else begin
        errors++;
        $display("A ready output or the LED was not low under reset");
    end

    one_ready_at_a_time: assert property (
        @(posedge clk) disable iff (rst) !(cpu_rsp.ready && host_rsp.ready)
    ) else begin
        errors++;
        $display("Both masters received ready in the same cycle");
    end

    cpu_ready_needs_request: assert property (
        @(posedge clk) disable iff (rst) cpu_rsp.ready |-> cpu_req.valid
    ) else begin
        errors++;
        $display("cpu received ready without a pending request");
    end

    host_ready_needs_request: assert property (
        @(posedge clk) disable iff (rst) host_rsp.ready |-> host_req.valid
    ) else begin
        errors++;
        $display("host received ready without a pending request");
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] region_addr(input logic [7:0] region, input int word);
        region_addr = {region, word[21:0], 2'b00};
    endfunction

    function automatic logic [31:0] model_word(input int word);
        model_word = {sram_model[word*4+3], sram_model[word*4+2],
                      sram_model[word*4+1], sram_model[word*4]};
    endfunction

    // Unstrobed bytes keep their old value
    function automatic void model_write(input int word, input logic [3:0] strb,
                                        input logic [31:0] wdata);
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                sram_model[word*4+lane] = wdata[lane*8 +: 8];
            end
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // One transfer on one master; lat counts edges from the drive edge to ready
    task automatic bus_access(input bit host, input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int lat);
        soc_bus_pkg::iomem_req_t req;
        logic                    rdy;
        req.valid = 1'b1;
        req.wstrb = strb;
        req.addr  = addr;
        req.wdata = wdata;
        @(posedge clk);
        if (host) host_req <= req;
        else cpu_req <= req;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
            rdy = host ? host_rsp.ready : cpu_rsp.ready;
        end while (!rdy && lat < 40);
        if (!rdy) begin
            errors++;
            $display("No ready seen for a %s request", host ? "host" : "cpu");
        end
        rdata = host ? host_rsp.rdata : cpu_rsp.rdata;
        done_order.push_back(host);
        if (host) host_req.valid <= 1'b0;
        else cpu_req.valid <= 1'b0;
    endtask

    // Access with the other master quiet
    task automatic idle_access(input bit host, input logic [31:0] addr, input logic [3:0] strb,
                               input logic [31:0] wdata, input logic [31:0] exp_rdata,
                               input int exp_lat);
        logic [31:0] rdata;
        int          lat;
        bus_access(host, addr, strb, wdata, rdata, lat);
        check_value(host ? "host_rsp_o.ready latency" : "cpu_rsp_o.ready latency",
                    lat - 1, exp_lat);
        if (strb == 4'h0) begin
            check_value(host ? "host_rsp_o.rdata" : "cpu_rsp_o.rdata", rdata, exp_rdata);
        end
    endtask

    task automatic contend_read(input bit host, input int word);
        logic [31:0] rdata;
        int          lat;
        bus_access(host, region_addr(soc_map_pkg::REGION_SRAM, word), 4'h0, 32'h0, rdata, lat);
        check_value(host ? "host_rsp_o.rdata" : "cpu_rsp_o.rdata", rdata, model_word(word));
    endtask

    // Both masters raise valid on the same edge
    task automatic contend_pair(input int cpu_word, input int host_word, input bit first);
        done_order.delete();
        fork
            contend_read(1'b0, cpu_word);
            contend_read(1'b1, host_word);
        join
        assert (done_order.size() == 2 && done_order[0] == first) else begin
            errors++;
            $display("Contention pair did not complete in round-robin order");
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] data;
        logic [3:0]  strb;
        void'($urandom(32'hb01a));
        clk      = 1'b0;
        rst      = 1'b1;
        cpu_req  = '0;
        host_req = '0;
        button   = 1'b0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Host seeds full words so last served stays host
        for (int w = 0; w < 6; w++) begin
            data = $urandom;
            model_write(w, 4'hf, data);
            idle_access(1'b1, region_addr(soc_map_pkg::REGION_SRAM, w), 4'hf, data, 32'h0, 2);
        end
        contend_pair(0, 1, 1'b0);

        // Partial rewrites and readback from the cpu
        for (int w = 0; w < 6; w++) begin
            data = $urandom;
            strb = $urandom_range(15, 1);
            model_write(w, strb, data);
            idle_access(1'b0, region_addr(soc_map_pkg::REGION_SRAM, w), strb, data, 32'h0, 2);
        end
        for (int w = 0; w < 6; w++) begin
            idle_access(1'b0, region_addr(soc_map_pkg::REGION_SRAM, w), 4'h0, 32'h0,
                        model_word(w), 2);
        end
        // cpu was served last so host wins this tie
        contend_pair(2, 3, 1'b1);

        idle_access(1'b0, region_addr(8'h07, 5), 4'h0, 32'h0, 32'h0, 1);

        // LED on and then off
        for (int level = 1; level >= 0; level--) begin
            idle_access(1'b0, region_addr(soc_map_pkg::REGION_GPIO, soc_map_pkg::GPIO_LED_WORD),
                        4'h1, level, 32'h0, 2);
            check_value("led_o", led, level);
            idle_access(1'b0, region_addr(soc_map_pkg::REGION_GPIO, soc_map_pkg::GPIO_LED_WORD),
                        4'h0, 32'h0, level, 2);
        end
        for (int level = 1; level >= 0; level--) begin
            @(posedge clk);
            button <= level[0];
            repeat (4) @(posedge clk);
            idle_access(1'b0, region_addr(soc_map_pkg::REGION_GPIO, soc_map_pkg::GPIO_BTN_WORD),
                        4'h0, 32'h0, level, 2);
        end

        // Host writes back to back while the cpu idles
        for (int w = 8; w < 12; w++) begin
            data = $urandom;
            model_write(w, 4'hf, data);
            idle_access(1'b1, region_addr(soc_map_pkg::REGION_SRAM, w), 4'hf, data, 32'h0, 2);
        end
        for (int w = 8; w < 12; w++) begin
            idle_access(1'b1, region_addr(soc_map_pkg::REGION_SRAM, w), 4'h0, 32'h0,
                        model_word(w), 2);
        end

        repeat (2) @(posedge clk);
        $display("Run finished with %0d error(s) counted", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog allows 20 cycles per transfer plus reset
    initial begin
        repeat (NUM_TXNS * 20 + 8) @(posedge clk);
        $display("Timeout: bus traffic did not finish in time");
        $display("Errors found");
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/soc_map_pkg.sv
rtl/soc_bus_pkg.sv
rtl/iomem_arbiter.sv
rtl/iomem_decoder.sv
rtl/soc_sram.sv
rtl/soc_gpio.sv
rtl/soc_bus_top.sv
tests/soc_bus_tb.sv

// ==== Bender.yml ====
package:
  name: soc_bus

sources:
  - rtl/soc_map_pkg.sv
  - rtl/soc_bus_pkg.sv
  - rtl/iomem_arbiter.sv
  - rtl/iomem_decoder.sv
  - rtl/soc_sram.sv
  - rtl/soc_gpio.sv
  - rtl/soc_bus_top.sv
  - target: test
    files:
      - tests/soc_bus_tb.sv
